// File: sim.f
+incdir+.
busPkg.sv
phasePkg.sv
memIf.sv
phaseGen.sv
busArb.sv
memCtrl.sv
ks10Top.sv
tbClkGen.sv
tbChecker.sv
ks10_chk.sv
tb_top.sv

// File: tb_top.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module tb_top;
   import busPkg::*;

   localparam int randReqs    = 300;
   localparam int plannedReqs = 6 + 3 + 3 + randReqs;
   localparam int cycleLimit  = 8 * plannedReqs + 200;

   logic                clkT;
   logic                memRST;
   logic [`NUM_REQ-1:0] reqV;
   logic [`NUM_REQ-1:0] writeV;
   busAddr              addrV [`NUM_REQ];
   busWord              dataV [`NUM_REQ];
   logic                cslAck;
   logic                ubaAck;
   logic                cpuAck;
   logic [`NUM_REQ-1:0] ackVec;
   busWord              rdData;
   logic                nxm;
   logic                cpuRst;
   logic [31:0]         lfsrState = 32'h4de1b420;
   int                  cycleCnt = 0;
   int                  timeouts = 0;

   // Random traffic drawn before it is driven
   int     randOwner [randReqs];
   logic   randWrite [randReqs];
   busAddr randAddr  [randReqs];
   busWord randData  [randReqs];
   int     randGap   [randReqs];

   assign ackVec = {cpuAck, ubaAck, cslAck};

   tbClkGen u_clk (.clkT(clkT));

   ks10Top u_dut (
      .clkT      (clkT),
      .memRST    (memRST),
      .cslReq    (reqV[reqCsl]),
      .cslWrite  (writeV[reqCsl]),
      .cslAddr   (addrV[reqCsl]),
      .cslWrData (dataV[reqCsl]),
      .cslAck    (cslAck),
      .ubaReq    (reqV[reqUba]),
      .ubaWrite  (writeV[reqUba]),
      .ubaAddr   (addrV[reqUba]),
      .ubaWrData (dataV[reqUba]),
      .ubaAck    (ubaAck),
      .cpuReq    (reqV[reqCpu]),
      .cpuWrite  (writeV[reqCpu]),
      .cpuAddr   (addrV[reqCpu]),
      .cpuWrData (dataV[reqCpu]),
      .cpuAck    (cpuAck),
      .rdData    (rdData),
      .nxm       (nxm),
      .cpuRst    (cpuRst)
   );

   tbChecker u_check (
      .clkT     (clkT),
      .memRST   (memRST),
      .reqVec   (reqV),
      .writeVec (writeV),
      .addrs    (addrV),
      .wrDatas  (dataV),
      .ackVec   (ackVec),
      .rdData   (rdData),
      .nxm      (nxm),
      .cpuRst   (cpuRst)
   );

   // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [63:0] takeBits(input int n);
      logic [63:0] v;
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         v         = {v[62:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
      return v;
   endfunction

   // Hold the request until Ack and drop it in the next cycle
   task automatic runRequest(input int idx, input logic wr, input busAddr addr,
                             input busWord data);
      @(negedge clkT);
      reqV[idx]   = 1'b1;
      writeV[idx] = wr;
      addrV[idx]  = addr;
      dataV[idx]  = data;
      do
         @(posedge clkT);
      while (!ackVec[idx]);
      @(negedge clkT);
      reqV[idx] = 1'b0;
   endtask

   task automatic drawTraffic();
      for (int n = 0; n < randReqs; n++)
      begin
         randOwner[n] = int'(takeBits(2) % 3);
         randWrite[n] = (takeBits(1) != '0);
         randAddr[n]  = busAddr'(takeBits(11) % 1101);   // 0 to 1100
         randData[n]  = busWord'(takeBits(`WORD_BITS));
         randGap[n]   = int'(takeBits(2));
      end
   endtask

   task automatic randWorker(input int idx);
      for (int n = 0; n < randReqs; n++)
      begin
         if (randOwner[n] == idx)
         begin
            repeat (randGap[n]) @(negedge clkT);
            runRequest(idx, randWrite[n], randAddr[n], randData[n]);
         end
      end
   endtask

   task automatic finishRun();
      int totalErrs;
      totalErrs = u_check.valueErrs + u_check.otherErrs + timeouts;
      $display("Checks %0d, value errors %0d, other errors %0d, timeouts %0d",
               u_check.checks, u_check.valueErrs, u_check.otherErrs, timeouts);
      if (totalErrs == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   endtask

   ////////////////////////////////////////////////////////////
   initial
   begin
      busAddr addrs [`NUM_REQ];
      busWord words [`NUM_REQ];
      memRST = 1'b1;
      reqV   = '0;
      writeV = '0;
      foreach (addrV[i])
      begin
         addrV[i] = '0;
         dataV[i] = '0;
      end
      addrs = '{20'h00010, 20'h00155, 20'h003ff};
      words = '{36'h123456789, 36'habcdef012, 36'h5a5a5a5a5};
      repeat (10) @(negedge clkT);
      memRST = 1'b0;
      wait (cpuRst === 1'b0);

      u_check.testName     = "write-read";
      u_check.checkLatency = 1'b1;
      for (int i = 0; i < `NUM_REQ; i++)
      begin
         runRequest(i, 1'b1, addrs[i], words[i]);
         runRequest(i, 1'b0, addrs[i], '0);
      end
      u_check.checkLatency = 1'b0;

      u_check.testName = "priority";   // All three in one cycle
      u_check.prioNext = 0;
      u_check.prioMode = 1'b1;
      fork
         runRequest(reqCsl, 1'b0, addrs[0], '0);
         runRequest(reqUba, 1'b0, addrs[1], '0);
         runRequest(reqCpu, 1'b0, addrs[2], '0);
      join
      u_check.prioMode = 1'b0;

      // Alias of addrs[0] one memory size up and then the real word
      u_check.testName = "nxm";
      runRequest(reqCsl, 1'b1, addrs[0] + 20'h00400, 36'h777777777);
      runRequest(reqCsl, 1'b0, addrs[0] + 20'h00400, '0);
      runRequest(reqCsl, 1'b0, addrs[0], '0);

      u_check.testName = "random";
      drawTraffic();
      fork
         randWorker(reqCsl);
         randWorker(reqUba);
         randWorker(reqCpu);
      join
      repeat (4) @(negedge clkT);
      finishRun();
   end

   // Watchdog
   initial
   begin
      while (cycleCnt < cycleLimit)
      begin
         @(posedge clkT);
         cycleCnt++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      timeouts = 1;
      finishRun();
   end

endmodule

`default_nettype wire

// File: ks10_chk.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module ks10_chk (
   input logic                clkT,
   input logic                memRST,
   input logic [`NUM_REQ-1:0] reqVec,
   input logic [`NUM_REQ-1:0] ackVec
);

   ackOneHot: assert property (@(posedge clkT) disable iff (memRST) $onehot0(ackVec))
      else $error("More than one Ack in the same cycle");

   // Ack only to a requester still holding Req
   ackToReq: assert property (@(posedge clkT) disable iff (memRST)
      (ackVec & ~reqVec) == '0)
      else $error("Ack given to a requester with Req low");

   ackPulse: assert property (@(posedge clkT) disable iff (memRST)
      (ackVec != '0) |=> ((ackVec & $past(ackVec)) == '0))
      else $error("Ack held for more than one cycle");   // Single-cycle pulse

endmodule

bind busArb ks10_chk u_chk (
   .clkT   (clkT),
   .memRST (memRST),
   .reqVec (reqVec),
   .ackVec (ackVec)
);

`default_nettype wire

// File: tbChecker.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module tbChecker (
   input logic                clkT,
   input logic                memRST,
   input logic [`NUM_REQ-1:0] reqVec,
   input logic [`NUM_REQ-1:0] writeVec,
   input busPkg::busAddr      addrs [`NUM_REQ],
   input busPkg::busWord      wrDatas [`NUM_REQ],
   input logic [`NUM_REQ-1:0] ackVec,
   input busPkg::busWord      rdData,
   input logic                nxm,
   input logic                cpuRst
);
   import busPkg::*;

   busWord modelMem [1 << `MEM_ADDR_BITS];
   string  testName = "reset";
   bit     checkLatency = 1'b0;   // Set by the testbench for lone requests
   bit     prioMode = 1'b0;
   int     prioNext = 0;
   int     prioLastCyc = 0;
   int     checks = 0;
   int     valueErrs = 0;
   int     otherErrs = 0;
   int     cycle = 0;
   int     rstCycles = 0;
   int     relCycles = 0;
   int     startCyc [`NUM_REQ];
   bit     pending [`NUM_REQ];

   initial
   begin
      foreach (modelMem[a])
         modelMem[a] = '0;
   end

   // Expected {nxm, rdData} for an acknowledged request
   function automatic logic [`WORD_BITS:0] refAccess(input logic write, input busAddr addr);
      logic isNxm;
      isNxm = (addr >= (1 << `MEM_ADDR_BITS));
      if (write || isNxm)
         return {isNxm, {`WORD_BITS{1'b0}}};
      return {1'b0, modelMem[addr[`MEM_ADDR_BITS-1:0]]};
   endfunction

   task automatic checkAck(input int idx);
      logic [`WORD_BITS:0] expVal;
      int                  lat;
      expVal = refAccess(writeVec[idx], addrs[idx]);
      lat    = cycle - startCyc[idx];
      checks++;
      if (rdData !== expVal[`WORD_BITS-1:0])
      begin
         $display("[FAIL] %s: rdData at %h expected %h, actual %h", testName, addrs[idx],
                  expVal[`WORD_BITS-1:0], rdData);
         valueErrs++;
      end
      if (nxm !== expVal[`WORD_BITS])
      begin
         $display("[FAIL] %s: nxm at %h expected %b, actual %b", testName, addrs[idx],
                  expVal[`WORD_BITS], nxm);
         valueErrs++;
      end
      if (writeVec[idx] && !expVal[`WORD_BITS])
         modelMem[addrs[idx][`MEM_ADDR_BITS-1:0]] = wrDatas[idx];
      if (checkLatency && (lat < 3 || lat > 7))
      begin
         $display("%s: requester %0d waited %0d cycles for its Ack", testName, idx, lat);
         otherErrs++;
      end
      if (prioMode && (idx != prioNext || (prioNext > 0 && cycle - prioLastCyc != 4)))
      begin
         $display("%s: requester %0d acknowledged out of order or off the phase cycle",
                  testName, idx);
         otherErrs++;
      end
      prioLastCyc = cycle;
      prioNext++;
   endtask

   ////////////////////////////////////////////////////////////
   // Sampled on the rising edge, values of the cycle just ended
   always @(posedge clkT)
   begin
      logic expCpuRst;
      cycle++;
      if (memRST)
      begin
         rstCycles++;
         relCycles = 0;
         if (rstCycles > 1 && (ackVec !== '0 || nxm !== 1'b0 || cpuRst !== 1'b1))
         begin
            $display("Reset: an Ack, nxm or cpuRst left its reset level");
            otherErrs++;
         end
      end
      else
      begin
         relCycles++;
         expCpuRst = (relCycles <= 4);   // Falls 4 cycles after release
         if (relCycles <= 6 && cpuRst !== expCpuRst)
         begin
            $display("[FAIL] reset: cpuRst expected %b, actual %b", expCpuRst, cpuRst);
            valueErrs++;
         end
         for (int i = 0; i < `NUM_REQ; i++)
         begin
            if (reqVec[i] && !pending[i])
            begin
               pending[i]  = 1'b1;
               startCyc[i] = cycle;
            end
            if (ackVec[i])
            begin
               checkAck(i);
               pending[i] = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tbClkGen.sv
`default_nettype none
`timescale 1ns/10ps

module tbClkGen #(
   parameter real halfPeriod = 4.0   // 8 ns period
) (
   output logic clkT
);

   initial
   begin
      clkT = 1'b0;
      forever #(halfPeriod) clkT = ~clkT;
   end

endmodule

`default_nettype wire

// File: ks10Top.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module ks10Top (
   input  logic           clkT,
   input  logic           memRST,
   // Console
   input  logic           cslReq,
   input  logic           cslWrite,
   input  busPkg::busAddr cslAddr,
   input  busPkg::busWord cslWrData,
   output logic           cslAck,
   // Unibus adapter port
   input  logic           ubaReq,
   input  logic           ubaWrite,
   input  busPkg::busAddr ubaAddr,
   input  busPkg::busWord ubaWrData,
   output logic           ubaAck,
   // CPU port
   input  logic           cpuReq,
   input  logic           cpuWrite,
   input  busPkg::busAddr cpuAddr,
   input  busPkg::busWord cpuWrData,
   output logic           cpuAck,
   // Shared returns
   output busPkg::busWord rdData,
   output logic           nxm,
   output logic           cpuRst
);
   import busPkg::*;

   phasePkg::busPhase   phase;
   logic [`NUM_REQ-1:0] reqVec;
   busRequest           reqs [`NUM_REQ];
   logic [`NUM_REQ-1:0] ackVec;

   memIf memBus ();

   ////////////////////////////////////////////////////////////
   // Requester packing
   ////////////////////////////////////////////////////////////

   assign reqVec[reqCsl] = cslReq;
   assign reqVec[reqUba] = ubaReq;
   assign reqVec[reqCpu] = cpuReq;

   assign reqs[reqCsl] = '{write: cslWrite, addr: cslAddr, wrData: cslWrData};
   assign reqs[reqUba] = '{write: ubaWrite, addr: ubaAddr, wrData: ubaWrData};
   assign reqs[reqCpu] = '{write: cpuWrite, addr: cpuAddr, wrData: cpuWrData};

   assign cslAck = ackVec[reqCsl];
   assign ubaAck = ackVec[reqUba];
   assign cpuAck = ackVec[reqCpu];

   // Read data and NXM straight off the memory side
   assign rdData = memBus.rdData;
   assign nxm    = memBus.nxm;

   ////////////////////////////////////////////////////////////
   // Backplane blocks
   ////////////////////////////////////////////////////////////

   phaseGen u_phase (
      .clkT   (clkT),
      .memRST (memRST),
      .phase  (phase),
      .cpuRst (cpuRst)
   );

   busArb u_arb (
      .clkT   (clkT),
      .memRST (memRST),
      .phase  (phase),
      .reqVec (reqVec),
      .reqs   (reqs),
      .ackVec (ackVec),
      .mem    (memBus.arb)
   );

   memCtrl u_mem (
      .clkT   (clkT),
      .memRST (memRST),
      .phase  (phase),
      .mem    (memBus.mem)
   );

endmodule

`default_nettype wire

// File: memCtrl.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module memCtrl (
   input  logic              clkT,
   input  logic              memRST,
   input  phasePkg::busPhase phase,
   memIf.mem                 mem
);
   import busPkg::*;
   import phasePkg::*;

   localparam int memWords = 1 << `MEM_ADDR_BITS;

   busWord memArray [memWords];

   logic   opActive;               // Latched between start and phT3
   logic   opWrite;
   busAddr opAddr;
   busWord opData;
   logic   opNxm;
   logic   doAccess;

   // Anything above the implemented words is nonexistent
   assign opNxm    = (opAddr[`ADDR_BITS-1:`MEM_ADDR_BITS] != '0);
   assign doAccess = opActive && (phase == phT3);

   ////////////////////////////////////////////////////////////
   // Cycle control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         opActive <= 1'b0;
         mem.done <= 1'b0;
         mem.nxm  <= 1'b0;
      end
      else
      begin
         if (mem.start)
            opActive <= 1'b1;
         else if (doAccess)
            opActive <= 1'b0;
         mem.done <= doAccess;           // High through phT4
         mem.nxm  <= doAccess && opNxm;
      end
   end

   // Request fields held for the rest of the phase cycle
   always_ff @(posedge clkT)
   begin
      if (mem.start)
      begin
         opWrite <= mem.write;
         opAddr  <= mem.addr;
         opData  <= mem.wrData;
      end
   end

   ////////////////////////////////////////////////////////////
   // Array access in phT3
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (doAccess)
      begin
         if (opWrite && !opNxm)
            memArray[opAddr[`MEM_ADDR_BITS-1:0]] <= opData;

         if (opWrite || opNxm)
            mem.rdData <= '0;
         else
            mem.rdData <= memArray[opAddr[`MEM_ADDR_BITS-1:0]];
      end
   end

endmodule

`default_nettype wire

// File: busArb.sv
`include "ks10_config.svh"
`default_nettype none
`timescale 1ns/10ps

module busArb (
   input  logic                clkT,
   input  logic                memRST,
   input  phasePkg::busPhase   phase,
   input  logic [`NUM_REQ-1:0] reqVec,
   input  busPkg::busRequest   reqs [`NUM_REQ],
   output logic [`NUM_REQ-1:0] ackVec,
   memIf.arb                   mem
);
   import busPkg::*;
   import phasePkg::*;

   logic [`NUM_REQ-1:0] eligible;
   logic [`NUM_REQ-1:0] lastAck;     // Acks from previous cycle
   logic                grantHit;
   reqIndex             grantIdx;
   logic                busy;        // Access open in memory
   reqIndex             owner;

   ////////////////////////////////////////////////////////////
   // Request selection
   ////////////////////////////////////////////////////////////

   // A requester that was just acked may still show its old Req
   assign eligible = reqVec & ~lastAck;

   // Scan from lowest priority up so the last hit wins
   always_comb
   begin
      grantHit = 1'b0;
      grantIdx = reqCsl;
      for (int i = `NUM_REQ - 1; i >= 0; i--)
      begin
         if (eligible[i])
         begin
            grantHit = 1'b1;
            grantIdx = reqIndex'(i);
         end
      end
   end

   // Grant only at the top of a phase cycle
   assign mem.start  = (phase == phT1) && !busy && grantHit;
   assign mem.write  = reqs[grantIdx].write;
   assign mem.addr   = reqs[grantIdx].addr;
   assign mem.wrData = reqs[grantIdx].wrData;

   ////////////////////////////////////////////////////////////
   // Ownership and acknowledge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         busy  <= 1'b0;
         owner <= reqCsl;
      end
      else if (mem.start)
      begin
         busy  <= 1'b1;
         owner <= grantIdx;
      end
      else if (mem.done)
      begin
         busy <= 1'b0;   // Free for the next phT1
      end
   end

   // Ack follows done in the same cycle
   always_comb
   begin
      for (int i = 0; i < `NUM_REQ; i++)
      begin
         ackVec[i] = mem.done && busy && (owner == reqIndex'(i));
      end
   end

   always_ff @(posedge clkT)
   begin
      if (memRST)
         lastAck <= '0;
      else
         lastAck <= ackVec;
   end

endmodule

`default_nettype wire

// File: phaseGen.sv
`default_nettype none
`timescale 1ns/10ps

////////////////////////////////////////////////////////////
// Bus phase ring
////////////////////////////////////////////////////////////

module phaseGen (
   input  logic              clkT,
   input  logic              memRST,
   output phasePkg::busPhase phase,
   output logic              cpuRst
);
   import phasePkg::*;

   // Phase steps once per clock, parked in phT1 while in reset.
   // The bus side stays in reset until the ring has gone around
   // once, so every master starts on a clean phT1.
   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         phase  <= phT1;
         cpuRst <= 1'b1;
      end
      else
      begin
         phase <= phaseNext(phase);
         if (phase == phT4)
         begin
            cpuRst <= 1'b0;   // Released on the edge leaving phT4
         end
      end
   end

endmodule

`default_nettype wire

// File: memIf.sv
`default_nettype none
`timescale 1ns/10ps

interface memIf;
   import busPkg::*;

   logic   start;          // Pulse in phT1
   logic   write;
   busAddr addr;
   busWord wrData;

   busWord rdData;         // Zero for writes and NXM
   logic   done;           // Pulse in phT4
   logic   nxm;            // Valid with done

   // Arbiter side
   modport arb (
      output start, write, addr, wrData,
      input  rdData, done, nxm
   );

   // Memory controller side
   modport mem (
      input  start, write, addr, wrData,
      output rdData, done, nxm
   );

endinterface

`default_nettype wire

// File: phasePkg.sv
`default_nettype none

package phasePkg;

   // Four bus timing phases per memory cycle
   typedef enum logic [1:0] {phT1, phT2, phT3, phT4} busPhase;

   function automatic busPhase phaseNext(input busPhase cur);
      case (cur)
         phT1:    return phT2;
         phT2:    return phT3;
         phT3:    return phT4;
         default: return phT1;   // Wrap after phT4
      endcase
   endfunction

endpackage

`default_nettype wire

// File: busPkg.sv
`include "ks10_config.svh"
`default_nettype none

package busPkg;

   // One backplane data word
   typedef logic [`WORD_BITS-1:0] busWord;

   typedef logic [`ADDR_BITS-1:0] busAddr;

   // Request as presented by a bus master
   typedef struct packed
   {
      logic   write;
      busAddr addr;
      busWord wrData;
   } busRequest;

   // Requester slots, lower value wins arbitration
   typedef enum logic [1:0]
   {
      reqCsl = 2'd0,
      reqUba = 2'd1,
      reqCpu = 2'd2
   } reqIndex;

endpackage

`default_nettype wire

// File: ks10_config.svh
`ifndef KS10_CONFIG_SVH
`define KS10_CONFIG_SVH

`default_nettype none

////////////////////////////////////////////////////////////
// Backplane sizes
////////////////////////////////////////////////////////////

`define WORD_BITS     36      // KS10 data word
`define ADDR_BITS     20      // Physical address

// Implemented memory is 2**MEM_ADDR_BITS words
`define MEM_ADDR_BITS 10

`define NUM_REQ       3       // Console, UBA port, CPU port

`default_nettype wire

`endif
